//--- logic/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // datapath and instruction widths
    localparam int XLEN = 64;
    localparam int ILEN = 32;

    // opcode bits 6:2 of SYSTEM instructions, bits 1:0 are always 2'b11
    localparam logic [4:0] OPC_SYSTEM = 5'b11100;

    // funct3 codes of the SYSTEM major opcode
    localparam logic [2:0] F3_PRIV  = 3'b000;
    localparam logic [2:0] F3_CSRRW = 3'b001;
    localparam logic [2:0] F3_CSRRS = 3'b010;
    localparam logic [2:0] F3_CSRRC = 3'b011;

    // funct12 codes of privileged instructions (funct3 == 0)
    localparam logic [11:0] F12_ECALL = 12'h000;
    localparam logic [11:0] F12_MRET  = 12'h302;

    // bits 31:20 carry a CSR address for csrrw/csrrs/csrrc
    // and a funct12 code for ecall/mret, so the word has two views
    typedef union packed {
        struct packed {
            logic [11:0] csr;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } csr_fmt;
        struct packed {
            logic [11:0] funct12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } priv_fmt;
    } instr_u;

endpackage

//--- logic/trap_pkg.sv
package trap_pkg;

    // machine-mode CSR addresses handled here
    localparam logic [11:0] ADDR_MSTATUS = 12'h300;
    localparam logic [11:0] ADDR_MIE     = 12'h304;
    localparam logic [11:0] ADDR_MTVEC   = 12'h305;
    localparam logic [11:0] ADDR_MEPC    = 12'h341;
    localparam logic [11:0] ADDR_MCAUSE  = 12'h342;
    localparam logic [11:0] ADDR_MIP     = 12'h344;

    // bit positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MIE_MTIE     = 7;
    localparam int MIP_MTIP     = 7;

    // mcause values
    localparam logic [riscv_isa_pkg::XLEN-1:0] CAUSE_ECALL_M =
        riscv_isa_pkg::XLEN'(11);
    localparam logic [riscv_isa_pkg::XLEN-1:0] CAUSE_TIMER_M =
        {1'b1, {(riscv_isa_pkg::XLEN-4){1'b0}}, 3'd7};

    // MPP = machine, UXL = SXL = 64-bit
    localparam logic [riscv_isa_pkg::XLEN-1:0] MSTATUS_RESET =
        64'h0000_000A_0000_1800;

endpackage

//--- logic/csr_cmd_if.sv
`timescale 1ns/1ps

interface csr_cmd_if;

    logic                           is_csr;
    logic [2:0]                     op;
    logic [11:0]                    addr;
    logic [riscv_isa_pkg::XLEN-1:0] wdata;
    logic                           is_ecall;
    logic                           is_mret;

    modport dec (
        output is_csr, op, addr, wdata, is_ecall, is_mret
    );

    // trap control only needs the instruction class
    modport ctrl (
        input is_csr, is_ecall, is_mret
    );

    modport file (
        input is_csr, op, addr, wdata
    );

endinterface

//--- logic/trap_evt_if.sv
`timescale 1ns/1ps

interface trap_evt_if;

    logic                           commit_wr;
    logic                           take_trap;
    logic                           trap_is_intr;
    logic                           do_mret;
    logic [riscv_isa_pkg::XLEN-1:0] trap_pc;
    logic                           set_mtip;

    modport ctrl (
        output commit_wr, take_trap, trap_is_intr, do_mret, trap_pc, set_mtip
    );

    modport file (
        input commit_wr, take_trap, trap_is_intr, do_mret, trap_pc, set_mtip
    );

endinterface

//--- logic/csr_decoder.sv
`timescale 1ns/1ps

module csr_decoder (
    input  riscv_isa_pkg::instr_u           instr_i,
    input  logic [riscv_isa_pkg::XLEN-1:0]  rs1_data_i,
    input  logic                            instr_valid_i,
    csr_cmd_if.dec                          cmd
);

    logic is_system;
    logic f3_csr;
    logic priv_regs_zero;

    // major opcode check, only for a valid slot
    assign is_system = instr_valid_i
                    && (instr_i.csr_fmt.opcode[6:2] == riscv_isa_pkg::OPC_SYSTEM)
                    && (instr_i.csr_fmt.opcode[1:0] == 2'b11);

    // register forms only, immediate forms fall through
    assign f3_csr = (instr_i.csr_fmt.funct3 == riscv_isa_pkg::F3_CSRRW)
                 || (instr_i.csr_fmt.funct3 == riscv_isa_pkg::F3_CSRRS)
                 || (instr_i.csr_fmt.funct3 == riscv_isa_pkg::F3_CSRRC);

    // ecall and mret encode rs1 and rd as zero
    assign priv_regs_zero = (instr_i.priv_fmt.rs1 == 5'd0)
                         && (instr_i.priv_fmt.rd == 5'd0)
                         && (instr_i.priv_fmt.funct3 == riscv_isa_pkg::F3_PRIV);

    assign cmd.is_csr = is_system && f3_csr;

    // privileged view of bits 31:20
    assign cmd.is_ecall = is_system && priv_regs_zero
                       && (instr_i.priv_fmt.funct12 == riscv_isa_pkg::F12_ECALL);

    assign cmd.is_mret = is_system && priv_regs_zero
                      && (instr_i.priv_fmt.funct12 == riscv_isa_pkg::F12_MRET);

    // access view of bits 31:20
    assign cmd.op    = instr_i.csr_fmt.funct3;
    assign cmd.addr  = instr_i.csr_fmt.csr;
    assign cmd.wdata = rs1_data_i;

endmodule

//--- logic/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl (
    input  logic [riscv_isa_pkg::XLEN-1:0]  pc_i,
    input  logic                            stall_n_i,
    input  logic                            timer_int_i,
    input  logic [riscv_isa_pkg::XLEN-1:0]  mtvec_i,
    input  logic [riscv_isa_pkg::XLEN-1:0]  mepc_i,
    input  logic                            mstatus_mie_i,
    input  logic                            mie_mtie_i,
    input  logic                            mip_mtip_i,
    csr_cmd_if.ctrl                         cmd,
    trap_evt_if.ctrl                        evt,
    output logic                            redirect_o,
    output logic [riscv_isa_pkg::XLEN-1:0]  redirect_pc_o,
    output logic                            intr_pending_o
);

    logic intr_enabled;
    logic intr_pending;
    logic take_intr;
    logic take_ecall;
    logic take_trap;
    logic do_mret;

    // global and timer enables both on
    assign intr_enabled = mie_mtie_i && mstatus_mie_i;
    assign intr_pending = mip_mtip_i && intr_enabled;

    // interrupt wins over whatever sits in execute
    assign take_intr  = stall_n_i && intr_pending;
    assign take_ecall = stall_n_i && !intr_pending && cmd.is_ecall;
    assign do_mret    = stall_n_i && !intr_pending && cmd.is_mret;
    assign take_trap  = take_intr || take_ecall;

    assign evt.take_trap    = take_trap;
    assign evt.trap_is_intr = take_intr;
    assign evt.do_mret      = do_mret;
    assign evt.trap_pc      = pc_i;

    // csr write of the instruction is dropped when an interrupt is taken
    assign evt.commit_wr = stall_n_i && !intr_pending && cmd.is_csr;

    // pending bit latches the pulse even while stalled
    assign evt.set_mtip = timer_int_i && intr_enabled;

    assign redirect_o    = take_trap || do_mret;
    assign redirect_pc_o = ({riscv_isa_pkg::XLEN{take_trap}} & mtvec_i)
                         | ({riscv_isa_pkg::XLEN{do_mret}} & mepc_i);

    assign intr_pending_o = intr_pending;

endmodule

//--- logic/csr_file.sv
`timescale 1ns/1ps

module csr_file (
    input  logic                            clk,
    input  logic                            rst_n,
    csr_cmd_if.file                         cmd,
    trap_evt_if.file                        evt,
    output logic [riscv_isa_pkg::XLEN-1:0]  rdata_o,
    output logic [riscv_isa_pkg::XLEN-1:0]  mtvec_o,
    output logic [riscv_isa_pkg::XLEN-1:0]  mepc_o,
    output logic                            mstatus_mie_o,
    output logic                            mie_mtie_o,
    output logic                            mip_mtip_o
);

    localparam int XLEN = riscv_isa_pkg::XLEN;

    logic [XLEN-1:0] mstatus;
    logic [XLEN-1:0] mie;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mip;

    logic sel_mstatus;
    logic sel_mie;
    logic sel_mtvec;
    logic sel_mepc;
    logic sel_mcause;
    logic sel_mip;

    logic op_rw;
    logic op_rs;
    logic op_rc;

    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] wr_val;
    logic [XLEN-1:0] mip_wr;

    // address decode, only for a real csr access
    assign sel_mstatus = cmd.is_csr && (cmd.addr == trap_pkg::ADDR_MSTATUS);
    assign sel_mie     = cmd.is_csr && (cmd.addr == trap_pkg::ADDR_MIE);
    assign sel_mtvec   = cmd.is_csr && (cmd.addr == trap_pkg::ADDR_MTVEC);
    assign sel_mepc    = cmd.is_csr && (cmd.addr == trap_pkg::ADDR_MEPC);
    assign sel_mcause  = cmd.is_csr && (cmd.addr == trap_pkg::ADDR_MCAUSE);
    assign sel_mip     = cmd.is_csr && (cmd.addr == trap_pkg::ADDR_MIP);

    // and-or read mux, zero when nothing is selected
    assign old_val = ({XLEN{sel_mstatus}} & mstatus)
                   | ({XLEN{sel_mie}}     & mie)
                   | ({XLEN{sel_mtvec}}   & mtvec)
                   | ({XLEN{sel_mepc}}    & mepc)
                   | ({XLEN{sel_mcause}}  & mcause)
                   | ({XLEN{sel_mip}}     & mip);

    assign rdata_o = old_val;

    assign op_rw = (cmd.op == riscv_isa_pkg::F3_CSRRW);
    assign op_rs = (cmd.op == riscv_isa_pkg::F3_CSRRS);
    assign op_rc = (cmd.op == riscv_isa_pkg::F3_CSRRC);

    // read-modify-write value
    assign wr_val = ({XLEN{op_rw}} & cmd.wdata)
                  | ({XLEN{op_rs}} & (old_val | cmd.wdata))
                  | ({XLEN{op_rc}} & (old_val & ~cmd.wdata));

    // software write to mip, a timer pulse in the same cycle still sets MTIP
    always_comb begin
        mip_wr = mip;
        if (evt.commit_wr && sel_mip) begin
            mip_wr = wr_val;
        end
        if (evt.set_mtip) begin
            mip_wr[trap_pkg::MIP_MTIP] = 1'b1;
        end
    end

    // mstatus: trap entry, trap return or software write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus <= trap_pkg::MSTATUS_RESET;
        end else if (evt.take_trap) begin
            mstatus[trap_pkg::MSTATUS_MPIE] <= mstatus[trap_pkg::MSTATUS_MIE];
            mstatus[trap_pkg::MSTATUS_MIE]  <= 1'b0;
        end else if (evt.do_mret) begin
            mstatus[trap_pkg::MSTATUS_MIE]  <= mstatus[trap_pkg::MSTATUS_MPIE];
            mstatus[trap_pkg::MSTATUS_MPIE] <= 1'b1;
        end else if (evt.commit_wr && sel_mstatus) begin
            mstatus <= wr_val;
        end
    end

    // mepc takes the trapping pc, low bits stay zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mepc <= '0;
        end else if (evt.take_trap) begin
            mepc <= {evt.trap_pc[XLEN-1:2], 2'b00};
        end else if (evt.commit_wr && sel_mepc) begin
            mepc <= {wr_val[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mcause <= '0;
        end else if (evt.take_trap) begin
            mcause <= evt.trap_is_intr ? trap_pkg::CAUSE_TIMER_M : trap_pkg::CAUSE_ECALL_M;
        end else if (evt.commit_wr && sel_mcause) begin
            mcause <= wr_val;
        end
    end

    // direct mode only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec <= '0;
        end else if (evt.commit_wr && sel_mtvec) begin
            mtvec <= {wr_val[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie <= '0;
        end else if (evt.commit_wr && sel_mie) begin
            mie <= wr_val;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mip <= '0;
        end else begin
            mip <= mip_wr;
        end
    end

    assign mtvec_o       = mtvec;
    assign mepc_o        = mepc;
    assign mstatus_mie_o = mstatus[trap_pkg::MSTATUS_MIE];
    assign mie_mtie_o    = mie[trap_pkg::MIE_MTIE];
    assign mip_mtip_o    = mip[trap_pkg::MIP_MTIP];

endmodule

//--- logic/machine_csr_unit.sv
`timescale 1ns/1ps

module machine_csr_unit (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [riscv_isa_pkg::XLEN-1:0]  pc_i,
    input  logic [riscv_isa_pkg::ILEN-1:0]  instr_i,
    input  logic                            instr_valid_i,
    input  logic [riscv_isa_pkg::XLEN-1:0]  rs1_data_i,
    input  logic                            stall_n_i,
    input  logic                            timer_int_i,
    output logic [riscv_isa_pkg::XLEN-1:0]  csr_rdata_o,
    output logic                            redirect_o,
    output logic [riscv_isa_pkg::XLEN-1:0]  redirect_pc_o,
    output logic                            intr_pending_o
);

    csr_cmd_if  cmd ();
    trap_evt_if evt ();

    logic [riscv_isa_pkg::XLEN-1:0] mtvec;
    logic [riscv_isa_pkg::XLEN-1:0] mepc;
    logic                           mstatus_mie;
    logic                           mie_mtie;
    logic                           mip_mtip;

    csr_decoder i_csr_decoder (
        .instr_i       (riscv_isa_pkg::instr_u'(instr_i)),
        .rs1_data_i    (rs1_data_i),
        .instr_valid_i (instr_valid_i),
        .cmd           (cmd.dec)
    );

    trap_ctrl i_trap_ctrl (
        .pc_i           (pc_i),
        .stall_n_i      (stall_n_i),
        .timer_int_i    (timer_int_i),
        .mtvec_i        (mtvec),
        .mepc_i         (mepc),
        .mstatus_mie_i  (mstatus_mie),
        .mie_mtie_i     (mie_mtie),
        .mip_mtip_i     (mip_mtip),
        .cmd            (cmd.ctrl),
        .evt            (evt.ctrl),
        .redirect_o     (redirect_o),
        .redirect_pc_o  (redirect_pc_o),
        .intr_pending_o (intr_pending_o)
    );

    csr_file i_csr_file (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (cmd.file),
        .evt           (evt.file),
        .rdata_o       (csr_rdata_o),
        .mtvec_o       (mtvec),
        .mepc_o        (mepc),
        .mstatus_mie_o (mstatus_mie),
        .mie_mtie_o    (mie_mtie),
        .mip_mtip_o    (mip_mtip)
    );

endmodule

//--- testbench/machine_csr_unit_assert.sv
`timescale 1ns/1ps

module machine_csr_unit_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        stall_n_i,
    input logic        redirect_i,
    input logic [63:0] mstatus_i,
    input logic [63:0] mie_i,
    input logic [63:0] mtvec_i,
    input logic [63:0] mepc_i,
    input logic [63:0] mcause_i,
    input logic [63:0] mip_i
);

    // mip without the timer pending bit
    logic [63:0] mip_rest;

    assign mip_rest = mip_i & ~(64'd1 << trap_pkg::MIP_MTIP);

    no_redirect_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n) !stall_n_i |-> !redirect_i
    ) else $error("redirect raised while stalled");

    // state seen one edge later must match
    stable_in_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        !stall_n_i |=> $stable(mstatus_i) && $stable(mie_i) && $stable(mtvec_i)
                       && $stable(mepc_i) && $stable(mcause_i) && $stable(mip_rest)
    ) else $error("csr state changed while stalled");

    mtvec_aligned: assert property (
        @(posedge clk) mtvec_i[1:0] == 2'b00
    ) else $error("mtvec low bits not zero");

endmodule

//--- testbench/tb_machine_csr_unit.sv
`timescale 1ns/1ps

module tb_machine_csr_unit;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DIRECTED     = 60;
    localparam int RANDOM_OPS   = 400;
    // a random op sits behind at most two stall cycles
    localparam int PLANNED_CYCLES = RESET_CYCLES + DIRECTED + RANDOM_OPS * 3;
    localparam logic [31:0] ECALL = 32'h0000_0073;
    localparam logic [31:0] MRET  = 32'h3020_0073;
    // model slot order with an unmapped address last
    localparam logic [11:0] ADDRS [7] = '{trap_pkg::ADDR_MSTATUS, trap_pkg::ADDR_MIE,
        trap_pkg::ADDR_MTVEC, trap_pkg::ADDR_MEPC, trap_pkg::ADDR_MCAUSE, trap_pkg::ADDR_MIP,
        12'h340};

    logic        clk;
    logic        rst_n;
    logic [63:0] pc_i;
    logic [31:0] instr_i;
    logic        instr_valid_i;
    logic [63:0] rs1_data_i;
    logic        stall_n_i;
    logic        timer_int_i;
    logic [63:0] csr_rdata_o;
    logic        redirect_o;
    logic [63:0] redirect_pc_o;
    logic        intr_pending_o;

    // slot order is mstatus, mie, mtvec, mepc, mcause, mip
    logic [5:0][63:0] ref_q;
    logic [5:0][63:0] ref_d;
    logic [63:0]      exp_rdata;
    logic [63:0]      exp_pc;
    logic             exp_redirect;
    logic             exp_pending;

    machine_csr_unit i_machine_csr_unit (.*);

    bind machine_csr_unit machine_csr_unit_assert i_machine_csr_unit_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall_n_i  (stall_n_i),
        .redirect_i (redirect_o),
        .mstatus_i  (i_csr_file.mstatus),
        .mie_i      (i_csr_file.mie),
        .mtvec_i    (i_csr_file.mtvec),
        .mepc_i     (i_csr_file.mepc),
        .mcause_i   (i_csr_file.mcause),
        .mip_i      (i_csr_file.mip)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] csr_word(input logic [2:0] f3, input logic [11:0] addr);
        return {addr, 5'd1, f3, 5'd2, 7'h73};
    endfunction

    // expected outputs of this cycle and register state after the next edge
    function automatic void model_step(input logic [5:0][63:0] cur,
                                       output logic [5:0][63:0] nxt,
                                       output logic [63:0] rdata, output logic redir,
                                       output logic [63:0] rpc, output logic pend);
        logic        sys;
        logic        acc;
        logic        priv_ok;
        logic        en;
        logic        trap;
        logic        ret;
        logic        hit;
        logic [2:0]  slot;
        logic [63:0] wv;
        sys     = instr_valid_i && (instr_i[6:0] == 7'h73);
        acc     = sys && (instr_i[14:12] inside {3'd1, 3'd2, 3'd3});
        // ecall and mret have rs1, funct3 and rd all zero
        priv_ok = sys && (instr_i[19:7] == 13'd0);
        en      = cur[1][trap_pkg::MIE_MTIE] && cur[0][trap_pkg::MSTATUS_MIE];
        pend    = cur[5][trap_pkg::MIP_MTIP] && en;
        hit     = 1'b0;
        slot    = 3'd0;
        for (int i = 0; i < 6; i++) begin
            if (acc && instr_i[31:20] == ADDRS[3'(i)]) begin
                hit  = 1'b1;
                slot = 3'(i);
            end
        end
        rdata = hit ? cur[slot] : 64'd0;
        case (instr_i[14:12])
            3'd1:    wv = rs1_data_i;
            3'd2:    wv = rdata | rs1_data_i;
            default: wv = rdata & ~rs1_data_i;
        endcase
        if (slot == 3'd2 || slot == 3'd3) wv[1:0] = 2'b00;
        trap = stall_n_i && (pend || (priv_ok && instr_i[31:20] == 12'h000));
        ret  = stall_n_i && !pend && priv_ok && (instr_i[31:20] == 12'h302);
        nxt  = cur;
        if (stall_n_i && !pend && hit) nxt[slot] = wv;
        if (trap) begin
            nxt[3] = {pc_i[63:2], 2'b00};
            nxt[4] = pend ? trap_pkg::CAUSE_TIMER_M : trap_pkg::CAUSE_ECALL_M;
            nxt[0][trap_pkg::MSTATUS_MPIE] = cur[0][trap_pkg::MSTATUS_MIE];
            nxt[0][trap_pkg::MSTATUS_MIE]  = 1'b0;
        end else if (ret) begin
            nxt[0][trap_pkg::MSTATUS_MIE]  = cur[0][trap_pkg::MSTATUS_MPIE];
            nxt[0][trap_pkg::MSTATUS_MPIE] = 1'b1;
        end
        // timer pulse is latched even under stall
        if (timer_int_i && en) nxt[5][trap_pkg::MIP_MTIP] = 1'b1;
        redir = trap || ret;
        rpc   = trap ? cur[2] : cur[3];
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic drive(input logic [63:0] pc, input logic [31:0] instr, input logic valid,
                         input logic [63:0] rs1, input logic stall_n, input logic timer);
        @(posedge clk);
        pc_i          <= pc;
        instr_i       <= instr;
        instr_valid_i <= valid;
        rs1_data_i    <= rs1;
        stall_n_i     <= stall_n;
        timer_int_i   <= timer;
    endtask

    // csrrs with a zero operand reads a register and leaves it as it is
    task automatic read_all(input logic [63:0] pc);
        for (int i = 0; i < 7; i++) begin
            drive(pc, csr_word(3'd2, ADDRS[3'(i)]), 1'b1, 64'd0, 1'b1, 1'b0);
        end
    endtask

    // compare on the falling edge and advance the model on the rising edge
    initial begin
        ref_q    = '0;
        ref_q[0] = trap_pkg::MSTATUS_RESET;
        forever begin
            @(negedge clk);
            model_step(ref_q, ref_d, exp_rdata, exp_redirect, exp_pc, exp_pending);
            check_value("csr_rdata_o", csr_rdata_o, exp_rdata);
            check_value("redirect_o", 64'(redirect_o), 64'(exp_redirect));
            if (exp_redirect) check_value("redirect_pc_o", redirect_pc_o, exp_pc);
            check_value("intr_pending_o", 64'(intr_pending_o), 64'(exp_pending));
            if (!rst_n) begin
                ref_d    = '0;
                ref_d[0] = trap_pkg::MSTATUS_RESET;
            end
            @(posedge clk);
            ref_q = ref_d;
        end
    end

    initial begin
        #(2 * PLANNED_CYCLES * CLK_PERIOD);
        $display("watchdog expired, the run did not end within %0d cycles", 2 * PLANNED_CYCLES);
        $display("Finished with errors");
        $fatal(1, "timeout");
    end

    initial begin
        int          kind;
        int          stalls;
        logic [63:0] pc;
        logic [63:0] data;
        logic [31:0] word;
        logic [2:0]  sel;
        void'($urandom(1667));
        rst_n         = 1'b0;
        pc_i          = '0;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        rs1_data_i    = '0;
        stall_n_i     = 1'b1;
        timer_int_i   = 1'b0;
        pc            = 64'h0000_0000_8000_0100;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        read_all(pc);
        // write rules where mtvec and mepc drop bits 1:0
        drive(pc, csr_word(3'd1, trap_pkg::ADDR_MTVEC), 1'b1, 64'h8000_0107, 1'b1, 1'b0);
        drive(pc, csr_word(3'd2, trap_pkg::ADDR_MTVEC), 1'b1, 64'h0000_0033, 1'b1, 1'b0);
        drive(pc, csr_word(3'd3, trap_pkg::ADDR_MTVEC), 1'b1, 64'h0000_0100, 1'b1, 1'b0);
        drive(pc, csr_word(3'd1, trap_pkg::ADDR_MEPC), 1'b1, 64'h4000_0abe, 1'b1, 1'b0);
        drive(pc, csr_word(3'd1, trap_pkg::ADDR_MCAUSE), 1'b1, 64'hdead, 1'b1, 1'b0);
        drive(pc, csr_word(3'd2, trap_pkg::ADDR_MSTATUS), 1'b1, 64'h8, 1'b1, 1'b0);
        drive(64'h1000_0206, ECALL, 1'b1, 64'd0, 1'b1, 1'b0);
        read_all(pc);
        drive(pc, MRET, 1'b1, 64'd0, 1'b1, 1'b0);
        // timer with enables set pre-empts the next csr write
        drive(pc, csr_word(3'd2, trap_pkg::ADDR_MIE), 1'b1, 64'h80, 1'b1, 1'b0);
        drive(pc, 32'h0, 1'b0, 64'd0, 1'b1, 1'b1);
        drive(64'h2000_0040, csr_word(3'd1, trap_pkg::ADDR_MCAUSE), 1'b1, 64'h5, 1'b1, 1'b0);
        drive(pc, csr_word(3'd3, trap_pkg::ADDR_MIP), 1'b1, 64'h80, 1'b1, 1'b0);
        drive(pc, MRET, 1'b1, 64'd0, 1'b1, 1'b0);
        // with the global enable off a pulse must not set MTIP
        drive(pc, csr_word(3'd3, trap_pkg::ADDR_MSTATUS), 1'b1, 64'h8, 1'b1, 1'b0);
        drive(pc, 32'h0, 1'b0, 64'd0, 1'b1, 1'b1);
        // ecall held behind a stall
        repeat (3) drive(64'h3000_0010, ECALL, 1'b1, 64'd0, 1'b0, 1'b0);
        drive(64'h3000_0010, ECALL, 1'b1, 64'd0, 1'b1, 1'b0);
        read_all(pc);
        repeat (RANDOM_OPS) begin
            kind = $urandom % 8;
            sel  = 3'($urandom % 7);
            pc   = {$urandom, $urandom};
            data = ($urandom % 2 == 0) ? {$urandom, $urandom} : 64'h88;
            case (kind)
                0, 1, 2: word = csr_word(3'($urandom % 3 + 1), ADDRS[sel]);
                3:       word = ECALL;
                4:       word = MRET;
                // immediate form is not decoded
                5:       word = csr_word(3'd5, ADDRS[sel]);
                default: word = 32'h0000_0013;
            endcase
            stalls = ($urandom % 4 == 0) ? ($urandom % 2 + 1) : 0;
            repeat (stalls) drive(pc, word, kind != 7, data, 1'b0, $urandom % 8 == 0);
            drive(pc, word, kind != 7, data, 1'b1, $urandom % 8 == 0);
        end
        read_all(pc);
        drive(pc, 32'h0, 1'b0, 64'd0, 1'b1, 1'b0);
        @(negedge clk);
        @(negedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- project.f
logic/riscv_isa_pkg.sv
logic/trap_pkg.sv
logic/csr_cmd_if.sv
logic/trap_evt_if.sv
logic/csr_decoder.sv
logic/trap_ctrl.sv
logic/csr_file.sv
logic/machine_csr_unit.sv
testbench/machine_csr_unit_assert.sv
testbench/tb_machine_csr_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, the log decides pass or fail
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_machine_csr_unit -f project.f -o tb_sim

# a fatal stop returns nonzero, the log search below gives the verdict
./obj_dir/tb_sim 2>&1 | tee sim.log

if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
